// File: ul_dfe_pkg.sv
package ul_dfe_pkg;

   localparam int N_ANTENNAS = 4;      // one chain per antenna
   localparam int SAMPLE_W   = 16;     // one I or Q component
   localparam int ACC_W      = 40;     // filter accumulator, room for coef growth

   // fraction bits dropped after each filter
   localparam int HB_FRAC_W  = 5;      // halfband taps sum to 32
   localparam int FIR_FRAC_W = 3;      // fir taps sum to 8

   localparam int HB_TAPS    = 7;
   localparam int FIR_TAPS   = 4;

   // symmetric halfband, odd taps zero except centre
   localparam int HB_COEF  [HB_TAPS]  = '{-1, 0, 9, 16, 9, 0, -1};
   localparam int FIR_COEF [FIR_TAPS] = '{1, 3, 3, 1};

   // gain stage widths
   localparam int GAIN_FRAC_W    = 16;  // Q1.15 unsigned, 32768 is unity
   localparam int GAIN_FRAC_BITS = 15;
   localparam int GAIN_SHIFT_W   = 4;   // power of two scaler, 0..15
   localparam int GAIN_PROD_W    = SAMPLE_W + GAIN_FRAC_W + 1;
   localparam int GAIN_WIDE_W    = GAIN_PROD_W + (2 ** GAIN_SHIFT_W) - 1;

   typedef logic signed [SAMPLE_W-1:0]     sample_t;
   typedef logic        [2*SAMPLE_W-1:0]   iq_t;        // {q, i}
   typedef logic signed [ACC_W-1:0]        acc_t;
   typedef logic        [GAIN_FRAC_W-1:0]  gain_frac_t;
   typedef logic        [GAIN_SHIFT_W-1:0] gain_shift_t;
   typedef logic signed [GAIN_PROD_W-1:0]  gain_prod_t;  // sample x fraction
   typedef logic signed [GAIN_WIDE_W-1:0]  gain_wide_t;  // product after max shift

   localparam sample_t SAMPLE_MAX = 16'sh7fff;
   localparam sample_t SAMPLE_MIN = 16'sh8000;

   // keeps half-lsb add in rnd_sat away from acc_t wrap
   localparam longint ACC_LIM = longint'(1) <<< (ACC_W - 2);

   // round half up, arithmetic shift, clamp to 16 bits
   function automatic sample_t rnd_sat(input acc_t din, input int frac_w);
      acc_t half;
      acc_t r;
      half = acc_t'(1) <<< (frac_w - 1);
      r    = (din + half) >>> frac_w;
      if (r > acc_t'(SAMPLE_MAX)) begin
         return SAMPLE_MAX;
      end
      if (r < acc_t'(SAMPLE_MIN)) begin
         return SAMPLE_MIN;
      end
      return sample_t'(r[SAMPLE_W-1:0]);
   endfunction

endpackage

// File: ul_hb_decim.sv
`timescale 1ns/1ns

module ul_hb_decim (
   input  logic             i_clk_3x,
   input  logic             i_reset,
   input  logic             i_en,      // level, low clears history and phase
   input  logic             i_valid,
   input  ul_dfe_pkg::iq_t  i_iq,
   output logic             o_valid,
   output ul_dfe_pkg::iq_t  o_iq
);
   import ul_dfe_pkg::*;

   // window is the new input plus 6 stored samples, newest first
   sample_t hist_i [HB_TAPS-1];
   sample_t hist_q [HB_TAPS-1];
   sample_t win_i  [HB_TAPS];
   sample_t win_q  [HB_TAPS];

   logic    phase;       // high when next valid completes a pair
   logic    sum_valid;   // tap sum registered
   logic    rnd_valid;   // rounded sample registered
   acc_t    sum_i;
   acc_t    sum_q;

   // folded halfband sum
   // pairs share one multiply, zero taps skipped
   function automatic acc_t hb_sum(input sample_t x [HB_TAPS]);
      acc_t s;
      s = acc_t'(x[HB_TAPS/2]) * acc_t'(HB_COEF[HB_TAPS/2]);  // centre tap
      for (int k = 0; k < HB_TAPS/2; k++) begin
         if (HB_COEF[k] != 0) begin
            s = s + (acc_t'(x[k]) + acc_t'(x[HB_TAPS-1-k])) * acc_t'(HB_COEF[k]);
         end
      end
      return s;
   endfunction

   always_comb begin
      win_i[0] = sample_t'(i_iq[SAMPLE_W-1:0]);          // i in low half
      win_q[0] = sample_t'(i_iq[2*SAMPLE_W-1:SAMPLE_W]);
      for (int k = 1; k < HB_TAPS; k++) begin
         win_i[k] = hist_i[k-1];
         win_q[k] = hist_q[k-1];
      end
   end

   // control and history
   always_ff @(posedge i_clk_3x) begin
      if (i_reset || !i_en) begin
         for (int k = 0; k < HB_TAPS-1; k++) begin
            hist_i[k] <= '0;
            hist_q[k] <= '0;
         end
         phase     <= 1'b0;
         sum_valid <= 1'b0;
         rnd_valid <= 1'b0;
      end else begin
         sum_valid <= i_valid && phase;   // 2nd, 4th ... input
         rnd_valid <= sum_valid;
         if (i_valid) begin
            phase <= ~phase;
            for (int k = 0; k < HB_TAPS-1; k++) begin
               hist_i[k] <= win_i[k];  // shift by one
               hist_q[k] <= win_q[k];
            end
         end
      end
   end

   // payload pipe
   always_ff @(posedge i_clk_3x) begin
      if (i_valid && phase) begin
         sum_i <= hb_sum(win_i);
         sum_q <= hb_sum(win_q);
      end
      if (sum_valid) begin
         o_iq <= {rnd_sat(sum_q, HB_FRAC_W), rnd_sat(sum_i, HB_FRAC_W)};
      end
   end

   assign o_valid = rnd_valid & i_en;  // disabled antenna emits nothing

   // decimated output can never come back to back
   a_hb_no_b2b: assert property (@(posedge i_clk_3x) disable iff (i_reset)
      o_valid |=> !o_valid)
      else $error("ul_hb_decim: o_valid high in two consecutive cycles");

endmodule

// File: ul_fir_decim.sv
`timescale 1ns/1ns

module ul_fir_decim (
   input  logic             i_clk_3x,
   input  logic             i_reset,
   input  logic             i_en,
   input  logic             i_valid,   // from halfband, half rate
   input  ul_dfe_pkg::iq_t  i_iq,
   output logic             o_valid,
   output ul_dfe_pkg::iq_t  o_iq
);
   import ul_dfe_pkg::*;

   sample_t hist_i [FIR_TAPS-1];   // 3 stored + input = 4 taps
   sample_t hist_q [FIR_TAPS-1];
   sample_t win_i  [FIR_TAPS];
   sample_t win_q  [FIR_TAPS];

   logic    phase;
   logic    sum_valid;
   logic    rnd_valid;
   acc_t    sum_i;
   acc_t    sum_q;

   // plain mac over all taps
   function automatic acc_t fir_sum(input sample_t x [FIR_TAPS]);
      acc_t s;
      s = '0;
      for (int k = 0; k < FIR_TAPS; k++) begin
         s = s + acc_t'(x[k]) * acc_t'(FIR_COEF[k]);
      end
      return s;
   endfunction

   always_comb begin
      win_i[0] = sample_t'(i_iq[SAMPLE_W-1:0]);
      win_q[0] = sample_t'(i_iq[2*SAMPLE_W-1:SAMPLE_W]);
      for (int k = 1; k < FIR_TAPS; k++) begin
         win_i[k] = hist_i[k-1];  // older samples
         win_q[k] = hist_q[k-1];
      end
   end

   always_ff @(posedge i_clk_3x) begin
      if (i_reset || !i_en) begin
         for (int k = 0; k < FIR_TAPS-1; k++) begin
            hist_i[k] <= '0;
            hist_q[k] <= '0;
         end
         phase     <= 1'b0;  // restart pair count
         sum_valid <= 1'b0;
         rnd_valid <= 1'b0;
      end else begin
         sum_valid <= i_valid && phase;
         rnd_valid <= sum_valid;
         if (i_valid) begin
            phase <= ~phase;
            for (int k = 0; k < FIR_TAPS-1; k++) begin
               hist_i[k] <= win_i[k];
               hist_q[k] <= win_q[k];
            end
         end
      end
   end

   always_ff @(posedge i_clk_3x) begin
      if (i_valid && phase) begin
         sum_i <= fir_sum(win_i);
         sum_q <= fir_sum(win_q);
      end
      if (sum_valid) begin
         o_iq <= {rnd_sat(sum_q, FIR_FRAC_W), rnd_sat(sum_i, FIR_FRAC_W)};
      end
   end

   assign o_valid = rnd_valid & i_en;

   a_fir_no_b2b: assert property (@(posedge i_clk_3x) disable iff (i_reset)
      o_valid |=> !o_valid)
      else $error("ul_fir_decim: o_valid high in two consecutive cycles");

   // a disabled cycle empties the pipe, nothing comes out right after it
   a_fir_quiet_off: assert property (@(posedge i_clk_3x) disable iff (i_reset)
      !i_en |=> !o_valid)
      else $error("ul_fir_decim: o_valid high after antenna disabled");

endmodule

// File: ul_iq_gain.sv
`timescale 1ns/1ns

module ul_iq_gain (
   input  logic                     i_clk_3x,
   input  logic                     i_reset,
   input  logic                     i_en,
   input  logic                     i_valid,
   input  ul_dfe_pkg::iq_t          i_iq,
   input  logic                     i_gain_sign,   // 1 negates
   input  ul_dfe_pkg::gain_shift_t  i_gain_shift,  // left shift count
   input  ul_dfe_pkg::gain_frac_t   i_gain_frac,   // Q1.15
   output logic                     o_valid,
   output ul_dfe_pkg::iq_t          o_iq
);
   import ul_dfe_pkg::*;

   // shadow of gain settings, sampled every cycle
   logic        sign_q;
   gain_shift_t shift_q;
   gain_frac_t  frac_q;

   // stage 1, product plus the settings that go with it
   gain_prod_t  prod_i;
   gain_prod_t  prod_q;
   logic        sign_p;
   gain_shift_t shift_p;
   logic        mul_valid;
   logic        out_valid;

   // shift, round off Q1.15, saturate, apply sign
   function automatic sample_t gain_out(input gain_prod_t prod, input gain_shift_t sh,
                                        input logic neg);
      gain_wide_t wide;
      acc_t       acc;
      sample_t    r;
      wide = gain_wide_t'(prod) <<< sh;
      if (wide > gain_wide_t'(ACC_LIM)) begin
         acc = acc_t'(ACC_LIM);    // far past full scale anyway
      end else if (wide < -gain_wide_t'(ACC_LIM)) begin
         acc = -acc_t'(ACC_LIM);
      end else begin
         acc = acc_t'(wide);
      end
      r = rnd_sat(acc, GAIN_FRAC_BITS);
      if (neg) begin
         r = (r == SAMPLE_MIN) ? SAMPLE_MAX : -r;  // -(-32768) clamps
      end
      return r;
   endfunction

   always_ff @(posedge i_clk_3x) begin
      if (i_reset) begin
         sign_q  <= 1'b0;
         shift_q <= '0;
         frac_q  <= '0;
      end else begin
         sign_q  <= i_gain_sign;
         shift_q <= i_gain_shift;
         frac_q  <= i_gain_frac;
      end
   end

   always_ff @(posedge i_clk_3x) begin
      if (i_reset || !i_en) begin
         mul_valid <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         mul_valid <= i_valid;
         out_valid <= mul_valid;
      end
   end

   always_ff @(posedge i_clk_3x) begin
      if (i_valid) begin
         // fraction is unsigned, zero-extend before signed multiply
         prod_i  <= sample_t'(i_iq[SAMPLE_W-1:0]) * $signed({1'b0, frac_q});
         prod_q  <= sample_t'(i_iq[2*SAMPLE_W-1:SAMPLE_W]) * $signed({1'b0, frac_q});
         sign_p  <= sign_q;
         shift_p <= shift_q;
      end
      if (mul_valid) begin
         o_iq <= {gain_out(prod_q, shift_p, sign_p), gain_out(prod_i, shift_p, sign_p)};
      end
   end

   assign o_valid = out_valid & i_en;

   // fixed two cycle latency while enabled and out of reset
   a_gain_latency: assert property (@(posedge i_clk_3x) disable iff (i_reset)
      (i_en && $past(i_en) && $past(i_en, 2) && !$past(i_reset) && !$past(i_reset, 2))
      |-> (o_valid == $past(i_valid, 2)))
      else $error("ul_iq_gain: o_valid does not follow i_valid by two cycles");

endmodule

// File: ul_dfe_ant.sv
`timescale 1ns/1ns

module ul_dfe_ant (
   input  logic                                                i_clk_3x,
   input  logic                                                i_reset,
   input  logic             [ul_dfe_pkg::N_ANTENNAS-1:0]       i_in_valid,
   input  ul_dfe_pkg::iq_t  [ul_dfe_pkg::N_ANTENNAS-1:0]       i_in_iq,
   input  logic             [ul_dfe_pkg::N_ANTENNAS-1:0]       i_ant_en,
   input  logic             [ul_dfe_pkg::N_ANTENNAS-1:0]       i_gain_sign,
   input  ul_dfe_pkg::gain_shift_t [ul_dfe_pkg::N_ANTENNAS-1:0] i_gain_shift,
   input  ul_dfe_pkg::gain_frac_t  [ul_dfe_pkg::N_ANTENNAS-1:0] i_gain_frac,
   output logic             [ul_dfe_pkg::N_ANTENNAS-1:0]       o_out_valid,
   output ul_dfe_pkg::iq_t  [ul_dfe_pkg::N_ANTENNAS-1:0]       o_out_iq
);
   import ul_dfe_pkg::*;

   // per antenna: hb /2 -> fir /2 -> gain
   // input to output is 6 cycles from the valid closing a group of 4
   for (genvar a = 0; a < N_ANTENNAS; a++) begin : g_ant
      logic hb_valid;    // half rate
      iq_t  hb_iq;
      logic fir_valid;   // quarter rate
      iq_t  fir_iq;

      ul_hb_decim hb_inst (
         .i_clk_3x (i_clk_3x),
         .i_reset  (i_reset),
         .i_en     (i_ant_en[a]),
         .i_valid  (i_in_valid[a]),
         .i_iq     (i_in_iq[a]),
         .o_valid  (hb_valid),
         .o_iq     (hb_iq)
      );

      ul_fir_decim fir_inst (
         .i_clk_3x (i_clk_3x),
         .i_reset  (i_reset),
         .i_en     (i_ant_en[a]),
         .i_valid  (hb_valid),
         .i_iq     (hb_iq),
         .o_valid  (fir_valid),
         .o_iq     (fir_iq)
      );

      ul_iq_gain gain_inst (
         .i_clk_3x     (i_clk_3x),
         .i_reset      (i_reset),
         .i_en         (i_ant_en[a]),
         .i_valid      (fir_valid),
         .i_iq         (fir_iq),
         .i_gain_sign  (i_gain_sign[a]),
         .i_gain_shift (i_gain_shift[a]),
         .i_gain_frac  (i_gain_frac[a]),
         .o_valid      (o_out_valid[a]),
         .o_iq         (o_out_iq[a])
      );

      // two decimate-by-2 stages, so at most one output per 4 cycles
      a_ant_rate: assert property (@(posedge i_clk_3x) disable iff (i_reset)
         o_out_valid[a] |=> !o_out_valid[a] [*3])
         else $error("ul_dfe_ant: antenna %0d output faster than 1/4 rate", a);
   end

endmodule

// File: tb_ul_dfe_model.svh
`ifndef TB_UL_DFE_MODEL_SVH
`define TB_UL_DFE_MODEL_SVH

typedef iq_t iq_q_t [$];   // stream of {q, i} words

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

function automatic sample_t clamp16(input longint v);
   if (v > 32767) begin
      return 16'sh7fff;
   end
   if (v < -32768) begin
      return 16'sh8000;
   end
   return sample_t'(v);
endfunction

// add half lsb, drop frac bits, clamp
function automatic sample_t round_clamp(input longint v, input int frac);
   longint r;
   r = (v + (longint'(1) << (frac - 1))) >>> frac;
   return clamp16(r);
endfunction

// taps newest first, output on the 2nd, 4th ... input
function automatic void decim_filter(input iq_q_t x, input int coef [$], input int frac,
                                     output iq_q_t y);
   longint acc_i;
   longint acc_q;
   int     idx;
   y = {};
   for (int n = 1; n < x.size(); n += 2) begin
      acc_i = 0;
      acc_q = 0;
      for (int k = 0; k < coef.size(); k++) begin
         idx = n - k;
         if (idx >= 0) begin   // history before the first input is zero
            acc_i += longint'(coef[k]) * longint'(sample_t'(x[idx][15:0]));
            acc_q += longint'(coef[k]) * longint'(sample_t'(x[idx][31:16]));
         end
      end
      y.push_back({round_clamp(acc_q, frac), round_clamp(acc_i, frac)});
   end
endfunction

function automatic void hb_model(input iq_q_t x, output iq_q_t y);
   int taps [$];
   taps = '{-1, 0, 9, 16, 9, 0, -1};   // sum 32
   decim_filter(x, taps, 5, y);
endfunction

function automatic void fir_model(input iq_q_t x, output iq_q_t y);
   int taps [$];
   taps = '{1, 3, 3, 1};               // sum 8
   decim_filter(x, taps, 3, y);
endfunction

// one component: times Q1.15 fraction, scale by 2^shift, round, negate
function automatic sample_t gain_comp(input sample_t s, input logic neg,
                                      input gain_shift_t shift, input gain_frac_t frac);
   longint  p;
   sample_t r;
   p = longint'(s) * longint'(frac);
   p = p <<< int'(shift);
   r = round_clamp(p, 15);
   if (neg) begin
      r = clamp16(-longint'(r));
   end
   return r;
endfunction

function automatic iq_t gain_model(input iq_t x, input logic neg,
                                   input gain_shift_t shift, input gain_frac_t frac);
   return {gain_comp(sample_t'(x[31:16]), neg, shift, frac),
           gain_comp(sample_t'(x[15:0]), neg, shift, frac)};
endfunction

`endif

// File: tb_ul_dfe_ant.sv
`timescale 1ns/1ns

module tb_ul_dfe_ant;
   import ul_dfe_pkg::*;

   `include "tb_ul_dfe_model.svh"

   localparam int WAIT_LIMIT = 2000;   // cycles allowed per antenna wait

   logic                         clk_3x;
   logic                         reset;
   logic [N_ANTENNAS-1:0]        in_valid;
   iq_t  [N_ANTENNAS-1:0]        in_iq;
   logic [N_ANTENNAS-1:0]        ant_en;
   logic [N_ANTENNAS-1:0]        gain_sign;
   gain_shift_t [N_ANTENNAS-1:0] gain_shift;
   gain_frac_t  [N_ANTENNAS-1:0] gain_frac;
   logic [N_ANTENNAS-1:0]        out_valid;
   iq_t  [N_ANTENNAS-1:0]        out_iq;

   iq_q_t       stim [N_ANTENNAS];      // per antenna input stream
   iq_q_t       expect_q [N_ANTENNAS];
   iq_q_t       got_q [N_ANTENNAS];     // filled by the monitor
   logic [31:0] rng_state;

   ul_dfe_ant ul_dfe_ant_inst (
      .i_clk_3x     (clk_3x),
      .i_reset      (reset),
      .i_in_valid   (in_valid),
      .i_in_iq      (in_iq),
      .i_ant_en     (ant_en),
      .i_gain_sign  (gain_sign),
      .i_gain_shift (gain_shift),
      .i_gain_frac  (gain_frac),
      .o_out_valid  (out_valid),
      .o_out_iq     (out_iq)
   );

   initial begin
      clk_3x = 1'b0;
      forever #10 clk_3x = ~clk_3x;   // 20 ns period
   end

   // outputs are registered, stable at the falling edge
   always @(negedge clk_3x) begin
      for (int a = 0; a < N_ANTENNAS; a++) begin
         if (out_valid[a]) begin
            got_q[a].push_back(out_iq[a]);
         end
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // signed value of the given width, top bits of the draw
   function automatic sample_t rand_sample(input int bits);
      return sample_t'($signed(next_rand()) >>> (32 - bits));
   endfunction

   function automatic iq_t rand_iq(input int bits);
      return {rand_sample(bits), rand_sample(bits)};
   endfunction

   task automatic compare_iq(input string test, input iq_t exp_v, input iq_t act_v);
      if (act_v !== exp_v) begin
         $display("MISMATCH %s: expected %h, actual %h", test, exp_v, act_v);
         $display("test failed");
         $fatal(1, "%s: wrong output sample", test);
      end
   endtask

   task automatic compare_count(input string test, input int exp_n, input int act_n);
      if (act_n != exp_n) begin
         $display("MISMATCH %s: expected %0d samples, actual %0d", test, exp_n, act_n);
         $display("test failed");
         $fatal(1, "%s: wrong sample count", test);
      end
   endtask

   // lands 1 ns after the rising edge
   task automatic step();
      @(posedge clk_3x);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) step();
   endtask

   task automatic set_gain(input int a, input logic neg, input gain_shift_t sh,
                           input gain_frac_t fr);
      gain_sign[a]  = neg;
      gain_shift[a] = sh;
      gain_frac[a]  = fr;
   endtask

   task automatic clear_stim();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         stim[a] = {};
      end
   endtask

   task automatic wait_outputs(input string test);
      int cycles;
      for (int a = 0; a < N_ANTENNAS; a++) begin
         cycles = 0;
         while (got_q[a].size() < expect_q[a].size()) begin
            if (cycles >= WAIT_LIMIT) begin
               $display("%s: timeout, antenna %0d output missing, %0d of %0d samples seen",
                        test, a, got_q[a].size(), expect_q[a].size());
               $display("test failed");
               $fatal(1, "%s: antenna %0d stalled", test, a);
            end
            step();
            cycles++;
         end
      end
      idle(12);   // room for any extra sample to show up
   endtask

   // clear pulse, model, drive with random gaps, then check every antenna
   task automatic run_streams(input string test, input int gap_max,
                              input logic [N_ANTENNAS-1:0] clear_mask);
      logic [N_ANTENNAS-1:0] keep_en;
      iq_q_t                 hb_out;
      iq_q_t                 fir_out;
      int                    n_max;
      keep_en = ant_en;
      ant_en  = keep_en & ~clear_mask;   // one low cycle empties history
      step();
      ant_en  = keep_en;
      idle(2);
      n_max = 0;
      for (int a = 0; a < N_ANTENNAS; a++) begin
         got_q[a]    = {};
         expect_q[a] = {};
         if (ant_en[a]) begin
            hb_model(stim[a], hb_out);
            fir_model(hb_out, fir_out);
            foreach (fir_out[k]) begin
               expect_q[a].push_back(gain_model(fir_out[k], gain_sign[a], gain_shift[a],
                                                gain_frac[a]));
            end
         end
         if (stim[a].size() > n_max) begin
            n_max = stim[a].size();
         end
      end
      for (int i = 0; i < n_max; i++) begin
         for (int a = 0; a < N_ANTENNAS; a++) begin
            in_valid[a] = (i < stim[a].size());
            in_iq[a]    = in_valid[a] ? stim[a][i] : '0;
         end
         step();
         in_valid = '0;
         if (gap_max > 0) begin
            idle(int'(next_rand() % (gap_max + 1)));
         end
      end
      wait_outputs(test);
      for (int a = 0; a < N_ANTENNAS; a++) begin
         compare_count(test, expect_q[a].size(), got_q[a].size());
         for (int k = 0; k < expect_q[a].size(); k++) begin
            compare_iq(test, expect_q[a][k], got_q[a][k]);
         end
      end
   endtask

   task automatic dc_level();
      iq_t dc [N_ANTENNAS];
      clear_stim();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         dc[a] = {sample_t'(12000 - 5000 * a), sample_t'(3000 * a - 4000)};
         set_gain(a, 1'b0, '0, 16'h8000);   // unity
         repeat (32) stim[a].push_back(dc[a]);
      end
      run_streams("dc_level", 0, '1);
      for (int a = 0; a < N_ANTENNAS; a++) begin
         compare_iq("dc_level", dc[a], got_q[a][got_q[a].size()-1]);  // settled
      end
   endtask

   task automatic decimation_count();
      clear_stim();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         repeat (40) stim[a].push_back(rand_iq(16));
      end
      run_streams("decimation_count", 5, '1);
      for (int a = 0; a < N_ANTENNAS; a++) begin
         compare_count("decimation_count", 10, got_q[a].size());  // 4k in, k out
      end
   endtask

   task automatic saturation_clamp();
      clear_stim();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         set_gain(a, 1'b0, 4'd3, 16'h8000);   // x8
         for (int i = 0; i < 64; i++) begin
            // blocks of 16, i and q at opposite full scale
            stim[a].push_back(((i / 16) % 2) ? {16'sh7fff, 16'sh8000}
                                             : {16'sh8000, 16'sh7fff});
         end
      end
      run_streams("saturation_clamp", 0, '1);
      for (int a = 0; a < N_ANTENNAS; a++) begin
         compare_iq("saturation_clamp", {16'sh7fff, 16'sh8000},
                    got_q[a][got_q[a].size()-1]);
      end
   endtask

   task automatic gain_variation();
      iq_t x;
      clear_stim();
      set_gain(0, 1'b0, 4'd0, 16'd16384);   // half
      set_gain(1, 1'b1, 4'd1, 16'd32768);   // -2
      set_gain(2, 1'b0, 4'd2, 16'd40000);
      set_gain(3, 1'b1, 4'd0, 16'd65535);   // just under -2
      repeat (32) begin
         x = rand_iq(13);   // same input, headroom for the gains
         for (int a = 0; a < N_ANTENNAS; a++) begin
            stim[a].push_back(x);
         end
      end
      run_streams("gain_variation", 2, '1);
   endtask

   task automatic enable_restart();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         set_gain(a, 1'b0, '0, 16'h8000);
      end
      ant_en = '1;
      clear_stim();
      repeat (13) stim[2].push_back(rand_iq(16));   // odd count leaves phase set
      run_streams("enable_prime", 0, '1);
      ant_en[2] = 1'b0;
      for (int a = 0; a < N_ANTENNAS; a++) begin
         repeat (16) stim[a].push_back(rand_iq(16));
      end
      run_streams("enable_off", 1, '0);   // antenna 2 must stay silent
      ant_en[2] = 1'b1;
      clear_stim();
      repeat (16) stim[2].push_back(rand_iq(16));
      run_streams("enable_restart", 0, '0);   // model starts empty
   endtask

   task automatic random_streams();
      logic [31:0] r;
      clear_stim();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         r = next_rand();
         set_gain(a, r[0], gain_shift_t'(r[5:4]), gain_frac_t'(r[31:16]));
         repeat (64) stim[a].push_back(rand_iq(16));
      end
      run_streams("random_streams", 3, '1);
   endtask

   initial begin
      reset      = 1'b1;
      in_valid   = '0;
      in_iq      = '0;
      ant_en     = '1;
      gain_sign  = '0;
      gain_shift = '0;
      gain_frac  = '0;
      rng_state  = 32'h52a0_d9a1;
      repeat (2) @(posedge clk_3x);
      #1;
      reset = 1'b0;
      idle(2);
      dc_level();
      decimation_count();
      saturation_clamp();
      gain_variation();
      enable_restart();
      random_streams();
      $display("test passed");
      $finish;
   end

endmodule

// File: all.f
+incdir+.
ul_dfe_pkg.sv
ul_hb_decim.sv
ul_fir_decim.sv
ul_iq_gain.sv
ul_dfe_ant.sv
tb_ul_dfe_ant.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run with verilator, exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module tb_ul_dfe_ant -o tb_ul_dfe_ant &&
./obj_dir/tb_ul_dfe_ant || {
   echo "simulation run did not succeed"
   exit 1
}
